//--- rtl/controlUnit_params.svh
`ifndef CONTROL_UNIT_PARAMS_SVH
`define CONTROL_UNIT_PARAMS_SVH

// opcode field of the instruction word
`define CU_OPCODE_W 4

// register select masks, active low
// all ones selects no register
`define CU_REGSEL_W 6

// immediate bus toward the datapath
`define CU_IMM_W 16

// extra cycles the ALU opcode stays up after it is first presented
`define CU_ALU_HOLD 2

`endif

//--- rtl/controlUnitPkg.sv
`include "controlUnit_params.svh"

package controlUnitPkg;

  typedef enum logic [`CU_OPCODE_W-1:0] {
    opSub  = 4'b0001,
    opNot  = 4'b0010,
    opAnd  = 4'b0011,
    opOr   = 4'b0100,
    opXor  = 4'b0101,
    opXnor = 4'b0110,
    opAddi = 4'b0111,
    opMovi = 4'b1001,
    opMov  = 4'b1010,
    opSubi = 4'b1101,
    opAdd  = 4'b1111
  } opcode_e;

  // decoded instruction class, execNone marks an illegal opcode
  typedef enum logic [2:0] {
    execNone, execAlu, execAluImm, execMove, execMoveImm
  } execKind_e;

  typedef enum logic [3:0] {
    fetchBoot, fetchIdle, fetchPcOut, fetchMarHold, fetchMemReq,
    fetchMemWait, fetchRead, fetchOut, fetchIrLoad
  } fetchState_e;

  typedef enum logic [3:0] {
    aluIdle, aluOperand1, aluLatch1, aluRegOperand, aluRegLatch,
    aluImmOperand, aluImmLatch, aluCompute, aluHold, aluResult, aluWriteBack
  } aluState_e;

  typedef enum logic [3:0] {moveIdle, moveDrive, moveWrite} moveState_e;

  typedef enum logic [1:0] {dispFetch, dispDecode, dispExec} dispatchState_e;

  // memory side strobes of the fetch phase
  typedef struct packed {
    logic pcOut;
    logic marIn;
    logic memEn;
    logic marOut;
    logic rw;
    logic readFromMem;
    logic outToBus;
    logic irIn;
  } busCtrl_t;

  // datapath strobes of the execute phase
  typedef struct packed {
    logic                    aluIn1;
    logic                    aluIn2;
    logic [`CU_OPCODE_W-1:0] aluOp;
    logic                    aluOutRegIn;
    logic                    aluOutRegOut;
    logic [`CU_REGSEL_W-1:0] regOut;      // active low
    logic [`CU_REGSEL_W-1:0] regIn;       // active low
    logic [`CU_IMM_W-1:0]    immOut;
    logic                    immValid;
    logic                    incrPc;
    logic                    finish;      // last active cycle of a sequencer
  } execCtrl_t;

  localparam execCtrl_t execCtrlIdle = '{
    regOut: '1,
    regIn: '1,
    default: '0
  };

endpackage

//--- rtl/fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     mfc,
  input  logic                     fetchGo,
  output controlUnitPkg::busCtrl_t busCtrl,
  output logic                     fetchDone
);
  import controlUnitPkg::*;

  fetchState_e state;
  fetchState_e nextState;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= fetchBoot;  // all strobes low while in reset
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      fetchBoot:    nextState = fetchPcOut;  // first fetch needs no go
      fetchIdle: begin
        if (fetchGo) begin
          nextState = fetchPcOut;
        end
      end
      fetchPcOut:   nextState = fetchMarHold;
      fetchMarHold: nextState = fetchMemReq;
      fetchMemReq:  nextState = fetchMemWait;
      fetchMemWait: begin
        // no timeout, memory may take as long as it likes
        if (mfc) begin
          nextState = fetchRead;
        end
      end
      fetchRead:    nextState = fetchOut;
      fetchOut:     nextState = fetchIrLoad;
      fetchIrLoad:  nextState = fetchIdle;
      default:      nextState = fetchIdle;
    endcase
  end

  // Moore outputs, one strobe set per state
  always_comb begin
    busCtrl   = '0;
    fetchDone = 1'b0;
    case (state)
      fetchPcOut, fetchMarHold: begin
        busCtrl.pcOut = 1'b1;  // pc onto the bus
        busCtrl.marIn = 1'b1;
      end
      fetchMemReq, fetchMemWait: begin
        busCtrl.memEn  = 1'b1;
        busCtrl.marOut = 1'b1;
        busCtrl.rw     = 1'b1;  // read cycle
      end
      fetchRead: begin
        busCtrl.readFromMem = 1'b1;  // memory word into mdr
      end
      fetchOut: begin
        busCtrl.outToBus = 1'b1;
      end
      fetchIrLoad: begin
        busCtrl.outToBus = 1'b1;
        busCtrl.irIn     = 1'b1;
        fetchDone        = 1'b1;
      end
      default: begin
        busCtrl = '0;
      end
    endcase
  end

endmodule

//--- rtl/aluSequencer.sv
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module aluSequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic                      immediate,
  input  controlUnitPkg::opcode_e   opCode,
  input  logic [`CU_REGSEL_W-1:0]   para1,
  input  logic [`CU_REGSEL_W-1:0]   para2,
  output controlUnitPkg::execCtrl_t aluCtrl
);
  import controlUnitPkg::*;

  localparam int HoldW = $clog2(`CU_ALU_HOLD + 1);

  aluState_e               state;
  aluState_e               nextState;
  logic [HoldW-1:0]        holdCnt;
  opcode_e                 opLatched;
  logic [`CU_REGSEL_W-1:0] dstReg;     // first operand and destination
  logic [`CU_REGSEL_W-1:0] operand2;   // register mask or immediate
  logic                    immLatched;

  // instruction register may change once the sequence is running
  always_ff @(posedge clk) begin
    if (start && state == aluIdle) begin
      opLatched  <= opCode;
      dstReg     <= para1;
      operand2   <= para2;
      immLatched <= immediate;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= aluIdle;
      holdCnt <= '0;
    end else begin
      state <= nextState;
      if (state == aluCompute) begin
        holdCnt <= HoldW'(1);
      end else if (state == aluHold) begin
        holdCnt <= holdCnt + 1'b1;
      end
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      aluIdle: begin
        if (start) begin
          nextState = aluOperand1;
        end
      end
      aluOperand1:   nextState = aluLatch1;
      aluLatch1:     nextState = immLatched ? aluImmOperand : aluRegOperand;
      aluRegOperand: nextState = aluRegLatch;
      aluImmOperand: nextState = aluImmLatch;
      aluRegLatch, aluImmLatch: nextState = aluCompute;
      aluCompute:    nextState = aluHold;
      aluHold: begin
        if (holdCnt == HoldW'(`CU_ALU_HOLD)) begin
          nextState = aluResult;
        end
      end
      aluResult:     nextState = aluWriteBack;
      default:       nextState = aluIdle;  // write back ends the sequence
    endcase
  end

  always_comb begin
    aluCtrl = execCtrlIdle;
    case (state)
      aluOperand1: begin
        aluCtrl.regOut = dstReg;
        aluCtrl.incrPc = 1'b1;  // one pc step per instruction
      end
      aluLatch1: begin
        aluCtrl.regOut = dstReg;
        aluCtrl.aluIn1 = 1'b1;
      end
      aluRegOperand: aluCtrl.regOut = operand2;
      aluRegLatch: begin
        aluCtrl.regOut = operand2;
        aluCtrl.aluIn2 = 1'b1;
      end
      aluImmOperand, aluImmLatch: begin
        aluCtrl.immOut   = `CU_IMM_W'(operand2);  // zero extended
        aluCtrl.immValid = 1'b1;
        aluCtrl.aluIn2   = (state == aluImmLatch);
      end
      aluCompute, aluHold: aluCtrl.aluOp = opLatched;
      aluResult:     aluCtrl.aluOutRegIn = 1'b1;
      aluWriteBack: begin
        aluCtrl.aluOutRegOut = 1'b1;
        aluCtrl.regIn        = dstReg;
        aluCtrl.finish       = 1'b1;
      end
      default:       aluCtrl = execCtrlIdle;
    endcase
  end

endmodule

//--- rtl/moveSequencer.sv
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module moveSequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic                      immediate,
  input  logic [`CU_REGSEL_W-1:0]   para1,
  input  logic [`CU_REGSEL_W-1:0]   para2,
  output controlUnitPkg::execCtrl_t moveCtrl
);
  import controlUnitPkg::*;

  moveState_e              state;
  logic [`CU_REGSEL_W-1:0] p1;
  logic [`CU_REGSEL_W-1:0] p2;
  logic                    immLatched;  // movi when set

  always_ff @(posedge clk) begin
    if (start && state == moveIdle) begin
      p1         <= para1;
      p2         <= para2;
      immLatched <= immediate;
    end
  end

  // fixed two step sequence
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= moveIdle;
    end else begin
      case (state)
        moveIdle:  state <= start ? moveDrive : moveIdle;
        moveDrive: state <= moveWrite;
        default:   state <= moveIdle;
      endcase
    end
  end

  always_comb begin
    moveCtrl = execCtrlIdle;
    if (state == moveDrive || state == moveWrite) begin
      if (immLatched) begin
        moveCtrl.immOut   = `CU_IMM_W'(p1);  // movi: para1 is the value
        moveCtrl.immValid = 1'b1;
      end else begin
        moveCtrl.regOut = p2;  // mov: source register
      end
    end
    if (state == moveDrive) begin
      moveCtrl.incrPc = 1'b1;
    end
    if (state == moveWrite) begin
      moveCtrl.regIn  = immLatched ? p2 : p1;
      moveCtrl.finish = 1'b1;
    end
  end

endmodule

//--- rtl/instructionDispatch.sv
`timescale 1ns/1ps

module instructionDispatch (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      fetchDone,
  input  controlUnitPkg::opcode_e   opCode,
  input  controlUnitPkg::execCtrl_t aluCtrl,
  input  controlUnitPkg::execCtrl_t moveCtrl,
  output logic                      fetchGo,
  output logic                      aluStart,
  output logic                      moveStart,
  output logic                      aluImmediate,
  output logic                      moveImmediate,
  output controlUnitPkg::execCtrl_t execCtrl,
  output logic                      illegalOp
);
  import controlUnitPkg::*;

  dispatchState_e state;
  execKind_e      kind;
  logic           decoding;
  logic           seqFinish;

  always_comb begin
    case (opCode)
      opAdd, opSub, opNot, opAnd, opOr, opXor, opXnor: kind = execAlu;
      opAddi, opSubi: kind = execAluImm;
      opMov:          kind = execMove;
      opMovi:         kind = execMoveImm;
      default:        kind = execNone;  // load, store and unused codes
    endcase
  end

  assign decoding      = (state == dispDecode);
  assign aluStart      = decoding && (kind == execAlu || kind == execAluImm);
  assign moveStart     = decoding && (kind == execMove || kind == execMoveImm);
  assign aluImmediate  = (kind == execAluImm);
  assign moveImmediate = (kind == execMoveImm);
  assign illegalOp     = decoding && (kind == execNone);

  assign seqFinish = aluCtrl.finish | moveCtrl.finish;
  // illegal opcode refetches without a pc step
  assign fetchGo   = illegalOp | (state == dispExec && seqFinish);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= dispFetch;
    end else begin
      case (state)
        dispFetch:  state <= fetchDone ? dispDecode : dispFetch;
        dispDecode: state <= illegalOp ? dispFetch : dispExec;
        dispExec:   state <= seqFinish ? dispFetch : dispExec;
        default:    state <= dispFetch;
      endcase
    end
  end

  // only one sequencer is active, idle words are neutral here
  always_comb begin
    execCtrl.aluIn1       = aluCtrl.aluIn1 | moveCtrl.aluIn1;
    execCtrl.aluIn2       = aluCtrl.aluIn2 | moveCtrl.aluIn2;
    execCtrl.aluOp        = aluCtrl.aluOp | moveCtrl.aluOp;
    execCtrl.aluOutRegIn  = aluCtrl.aluOutRegIn | moveCtrl.aluOutRegIn;
    execCtrl.aluOutRegOut = aluCtrl.aluOutRegOut | moveCtrl.aluOutRegOut;
    execCtrl.regOut       = aluCtrl.regOut & moveCtrl.regOut;  // active low
    execCtrl.regIn        = aluCtrl.regIn & moveCtrl.regIn;
    execCtrl.immOut       = aluCtrl.immValid ? aluCtrl.immOut : moveCtrl.immOut;
    execCtrl.immValid     = aluCtrl.immValid | moveCtrl.immValid;
    execCtrl.incrPc       = aluCtrl.incrPc | moveCtrl.incrPc;
    execCtrl.finish       = seqFinish;
  end

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlUnit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      mfc,
  input  controlUnitPkg::opcode_e   opCode,
  input  logic [`CU_REGSEL_W-1:0]   para1,
  input  logic [`CU_REGSEL_W-1:0]   para2,
  output controlUnitPkg::busCtrl_t  busCtrl,
  output controlUnitPkg::execCtrl_t execCtrl,
  output logic                      illegalOp
);

  logic                      fetchGo;
  logic                      fetchDone;
  logic                      aluStart;
  logic                      moveStart;
  logic                      aluImmediate;
  logic                      moveImmediate;
  controlUnitPkg::execCtrl_t aluCtrl;
  controlUnitPkg::execCtrl_t moveCtrl;

  fetchSequencer fetchSequencer_i (
    .clk, .reset, .mfc, .fetchGo,
    .busCtrl, .fetchDone
  );

  aluSequencer aluSequencer_i (
    .clk, .reset,
    .start     (aluStart),
    .immediate (aluImmediate),
    .opCode, .para1, .para2,
    .aluCtrl
  );

  moveSequencer moveSequencer_i (
    .clk, .reset,
    .start     (moveStart),
    .immediate (moveImmediate),
    .para1, .para2,
    .moveCtrl
  );

  instructionDispatch instructionDispatch_i (
    .clk, .reset, .fetchDone, .opCode,
    .aluCtrl, .moveCtrl,
    .fetchGo, .aluStart, .moveStart,
    .aluImmediate, .moveImmediate,
    .execCtrl, .illegalOp
  );

endmodule

//--- dv/controlUnitTb.sv
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlUnitTb;
  import controlUnitPkg::*;

  localparam int NumInstr   = 24;  // eleven legal opcodes twice plus two illegal
  localparam int ClsIllegal = 0;
  localparam int ClsAlu     = 1;
  localparam int ClsAluImm  = 2;
  localparam int ClsMove    = 3;
  localparam int ClsMoveImm = 4;
  localparam execCtrl_t IdleWord = '{regOut: '1, regIn: '1, default: '0};

  typedef struct packed {
    logic [`CU_OPCODE_W-1:0] op;
    logic [`CU_REGSEL_W-1:0] p1;
    logic [`CU_REGSEL_W-1:0] p2;
  } instrWord_t;

  logic                    clk;
  logic                    reset;
  logic                    mfc;
  opcode_e                 opCode;
  logic [`CU_REGSEL_W-1:0] para1;
  logic [`CU_REGSEL_W-1:0] para2;
  busCtrl_t                busCtrl;
  execCtrl_t               execCtrl;
  logic                    illegalOp;

  instrWord_t              instrQueue[$];
  int                      mfcDelay[NumInstr + 4];
  int                      cyc;        // cycles since decode or -1 outside execute
  int                      mCls;
  logic [`CU_OPCODE_W-1:0] mOp;
  logic [`CU_REGSEL_W-1:0] mP1;
  logic [`CU_REGSEL_W-1:0] mP2;
  execCtrl_t               expExec;
  logic                    expIllegal;
  int                      incrCount;
  int                      illegalCount;
  int                      legalCount;
  int                      badCount;

  controlUnit controlUnit_i (
    .clk, .reset, .mfc, .opCode, .para1, .para2,
    .busCtrl, .execCtrl, .illegalOp
  );

  always #4 clk = ~clk;

  task automatic failRun(string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] want);
    failRun($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                      $time, name, got, want));
  endtask

  // opcode table of the instruction set
  function automatic int decodeClass(logic [`CU_OPCODE_W-1:0] op);
    case (op)
      4'b1111, 4'b0001, 4'b0010, 4'b0011, 4'b0100, 4'b0101, 4'b0110: return ClsAlu;
      4'b0111, 4'b1101: return ClsAluImm;
      4'b1010:          return ClsMove;
      4'b1001:          return ClsMoveImm;
      default:          return ClsIllegal;
    endcase
  endfunction

  function automatic int execLength(int cls);
    if (cls == ClsAlu || cls == ClsAluImm) begin
      return 9;
    end else if (cls == ClsMove || cls == ClsMoveImm) begin
      return 2;
    end
    return 0;
  endfunction

  // expected execute word for a cycle offset from decode
  function automatic execCtrl_t expectedExec(int c, int cls, logic [3:0] op,
                                             logic [5:0] p1, logic [5:0] p2);
    execCtrl_t e;
    e = IdleWord;
    if (cls == ClsAlu || cls == ClsAluImm) begin
      case (c)
        1: begin
          e.regOut = p1;
          e.incrPc = 1'b1;
        end
        2: begin
          e.regOut = p1;
          e.aluIn1 = 1'b1;
        end
        3, 4: begin
          if (cls == ClsAluImm) begin
            e.immOut   = `CU_IMM_W'(p2);
            e.immValid = 1'b1;
          end else begin
            e.regOut = p2;
          end
          e.aluIn2 = (c == 4);
        end
        5, 6, 7: e.aluOp = op;  // opcode plus two hold cycles
        8: e.aluOutRegIn = 1'b1;
        9: begin
          e.aluOutRegOut = 1'b1;
          e.regIn        = p1;
          e.finish       = 1'b1;
        end
        default: e = IdleWord;
      endcase
    end else if ((cls == ClsMove || cls == ClsMoveImm) && (c == 1 || c == 2)) begin
      if (cls == ClsMoveImm) begin
        e.immOut   = `CU_IMM_W'(p1);
        e.immValid = 1'b1;
      end else begin
        e.regOut = p2;
      end
      e.incrPc = (c == 1);
      e.finish = (c == 2);
      if (c == 2) begin
        e.regIn = (cls == ClsMoveImm) ? p2 : p1;
      end
    end
    return e;
  endfunction

  function automatic logic [5:0] packStrobes(execCtrl_t w);
    return {w.aluIn1, w.aluIn2, w.aluOutRegIn, w.aluOutRegOut, w.incrPc, w.finish};
  endfunction

  // cycle tracker for the instruction in flight
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      cyc  <= -1;
      mCls <= ClsIllegal;
      mOp  <= '0;
      mP1  <= '0;
      mP2  <= '0;
    end else begin
      if (cyc == 0) begin
        mCls <= decodeClass(opCode);  // instruction register seen at decode
        mOp  <= opCode;
        mP1  <= para1;
        mP2  <= para2;
      end
      if (busCtrl.irIn) begin
        cyc <= 0;
      end else if (cyc == 0) begin
        cyc <= (execLength(decodeClass(opCode)) > 0) ? 1 : -1;
      end else if (cyc > 0 && cyc < execLength(mCls)) begin
        cyc <= cyc + 1;
      end else begin
        cyc <= -1;
      end
    end
  end

  always_comb begin
    expExec    = expectedExec(cyc, mCls, mOp, mP1, mP2);
    expIllegal = (cyc == 0) && (decodeClass(opCode) == ClsIllegal);
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      incrCount    <= 0;
      illegalCount <= 0;
    end else begin
      if (execCtrl.incrPc) begin
        incrCount <= incrCount + 1;
      end
      if (illegalOp) begin
        illegalCount <= illegalCount + 1;
      end
    end
  end

  resetIdle: assert property (@(posedge clk) (reset || $fell(reset)) |->
      (busCtrl == '0 && execCtrl == IdleWord && !illegalOp))
    else failRun("strobes or illegalOp not idle around reset");
  firstFetch: assert property (@(posedge clk) $fell(reset) |=> busCtrl.pcOut && busCtrl.marIn)
    else failRun("pcOut and marIn not high in the first cycle after reset");
  fetchStart: assert property (@(posedge clk) disable iff (reset)
      $rose(busCtrl.pcOut) |-> busCtrl.marIn ##1 (busCtrl.pcOut && busCtrl.marIn)
      ##1 (busCtrl.memEn && !busCtrl.pcOut))
    else failRun("fetch did not present the pc for two cycles before the memory request");
  memTogether: assert property (@(posedge clk) disable iff (reset)
      busCtrl.memEn == busCtrl.marOut && busCtrl.memEn == busCtrl.rw)
    else failRun("memEn, marOut and rw are not aligned");
  memHold: assert property (@(posedge clk) disable iff (reset)
      busCtrl.memEn && !mfc |=> busCtrl.memEn)
    else failRun("memory request dropped before mfc was sampled");
  memRelease: assert property (@(posedge clk) disable iff (reset)
      busCtrl.memEn && mfc |=> (busCtrl.readFromMem && !busCtrl.memEn)
      ##1 (busCtrl.outToBus && !busCtrl.irIn) ##1 (busCtrl.outToBus && busCtrl.irIn))
    else failRun("irIn did not follow the mfc sample by exactly three cycles");
  busQuiet: assert property (@(posedge clk) disable iff (reset) cyc >= 0 |-> busCtrl == '0)
    else reportMismatch("busCtrl", $sampled(busCtrl), 0);
  regOutCheck: assert property (@(posedge clk) disable iff (reset)
      execCtrl.regOut == expExec.regOut)
    else reportMismatch("regOut", $sampled(execCtrl.regOut), $sampled(expExec.regOut));
  regInCheck: assert property (@(posedge clk) disable iff (reset)
      execCtrl.regIn == expExec.regIn)
    else reportMismatch("regIn", $sampled(execCtrl.regIn), $sampled(expExec.regIn));
  immCheck: assert property (@(posedge clk) disable iff (reset)
      {execCtrl.immValid, execCtrl.immOut} == {expExec.immValid, expExec.immOut})
    else reportMismatch("immValid,immOut", $sampled({execCtrl.immValid, execCtrl.immOut}),
                        $sampled({expExec.immValid, expExec.immOut}));
  aluOpCheck: assert property (@(posedge clk) disable iff (reset)
      execCtrl.aluOp == expExec.aluOp)
    else reportMismatch("aluOp", $sampled(execCtrl.aluOp), $sampled(expExec.aluOp));
  strobeCheck: assert property (@(posedge clk) disable iff (reset)
      packStrobes(execCtrl) == packStrobes(expExec))
    else reportMismatch("aluIn1,aluIn2,aluOutRegIn,aluOutRegOut,incrPc,finish",
                        $sampled(packStrobes(execCtrl)), $sampled(packStrobes(expExec)));
  illegalCheck: assert property (@(posedge clk) disable iff (reset) illegalOp == expIllegal)
    else reportMismatch("illegalOp", $sampled(illegalOp), $sampled(expIllegal));
  finishReturn: assert property (@(posedge clk) disable iff (reset)
      execCtrl.finish |=> busCtrl.pcOut)
    else failRun("pcOut did not rise in the cycle after finish");
  illegalReturn: assert property (@(posedge clk) disable iff (reset)
      illegalOp |=> busCtrl.pcOut)
    else failRun("pcOut did not rise in the cycle after illegalOp");

  // memory answers each read after a short random wait
  initial begin
    int idx;
    idx = 0;
    forever begin
      @(posedge clk);
      if (busCtrl.memEn) begin
        repeat (mfcDelay[idx % (NumInstr + 4)]) @(posedge clk);
        #1 mfc = 1'b1;
        @(posedge clk);
        #1 mfc = 1'b0;
        idx++;
      end
    end
  end

  task automatic waitForIrLoad();
    @(posedge clk);
    while (!busCtrl.irIn) begin
      @(posedge clk);
    end
  endtask

  task automatic buildProgram();
    instrWord_t w;
    instrWord_t tmp;
    int j;
    legalCount = 0;
    badCount   = 0;
    for (int op = 0; op < 16; op++) begin
      if (decodeClass(op) != ClsIllegal || op == 4'hB || op == 4'hC) begin
        for (int k = 0; k < ((decodeClass(op) == ClsIllegal) ? 1 : 2); k++) begin
          w.op = op;
          w.p1 = $urandom_range(0, 63);
          w.p2 = $urandom_range(0, 63);
          instrQueue.push_back(w);
          if (decodeClass(op) == ClsIllegal) begin
            badCount++;
          end else begin
            legalCount++;
          end
        end
      end
    end
    for (int i = instrQueue.size() - 1; i > 0; i--) begin  // shuffle
      j             = $urandom_range(0, i);
      tmp           = instrQueue[i];
      instrQueue[i] = instrQueue[j];
      instrQueue[j] = tmp;
    end
    foreach (mfcDelay[i]) begin
      mfcDelay[i] = $urandom_range(0, 5);
    end
  endtask

  initial begin
    void'($urandom(29));
    clk    = 1'b0;
    reset  = 1'b1;
    mfc    = 1'b0;
    opCode = opAdd;
    para1  = '0;
    para2  = '0;
    buildProgram();
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    foreach (instrQueue[i]) begin
      waitForIrLoad();
      #1;
      opCode = opcode_e'(instrQueue[i].op);
      para1  = instrQueue[i].p1;
      para2  = instrQueue[i].p2;
      @(posedge clk);
      #1;
      opCode = opcode_e'($urandom_range(0, 15));  // ir free to change after decode
      para1  = $urandom_range(0, 63);
      para2  = $urandom_range(0, 63);
    end
    @(posedge clk);
    while (!busCtrl.pcOut) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    incrTotal: assert (incrCount == legalCount)
      else reportMismatch("incrPc pulse count", incrCount, legalCount);
    illegalTotal: assert (illegalCount == badCount)
      else reportMismatch("illegalOp pulse count", illegalCount, badCount);
    $display("Test OK");
    $finish;
  end

  initial begin
    repeat (NumInstr * (20 + 5) + 50) @(posedge clk);
    failRun("watchdog expired, the run hung");
  end

endmodule

//--- controlUnit.f
+incdir+rtl
rtl/controlUnitPkg.sv
rtl/fetchSequencer.sv
rtl/aluSequencer.sv
rtl/moveSequencer.sv
rtl/instructionDispatch.sv
rtl/controlUnit.sv
dv/controlUnitTb.sv
